// ==== include/i2cMaster_defs.svh ====
`ifndef I2C_MASTER_DEFS_SVH
`define I2C_MASTER_DEFS_SVH

////////////////////////////////////////
// Register word addresses.
////////////////////////////////////////

// Baud divisor register.
`define I2C_ADDR_BAUD 4'h0
// Control and status register.
`define I2C_ADDR_CTRL 4'h4
// Data register.
`define I2C_ADDR_DATA 4'h8

////////////////////////////////////////
// Transfer framing.
////////////////////////////////////////

// Index of the final bus phase, 22 phases in all.
`define I2C_PHASE_LAST 5'd21

// Smallest usable tick period in clk cycles.
`define I2C_MIN_DIV 16'd4

`endif

// ==== design/i2cRegPkg.sv ====
`default_nettype none

package i2cRegPkg;

	////////////////////////////////////////
	// APB side of the register block.
	////////////////////////////////////////

	// Word address on the APB port.
	typedef logic [3:0] apbAddr;

	// Read and write data on the APB port.
	typedef logic [15:0] apbWord;

	////////////////////////////////////////
	// Register fields.
	////////////////////////////////////////

	// Tick period in clk cycles.
	// Bit 0 is always stored as zero.
	typedef logic [15:0] baudDiv;

	// Control field, bits 3..0 of the control register.
	// Bit 3 generates START.
	// Bit 2 generates STOP.
	// Bit 1 selects a write transfer.
	// Bit 0 enables the controller.
	typedef logic [3:0] ctrlBits;

endpackage

`default_nettype wire

// ==== design/i2cBusPkg.sv ====
`default_nettype none

package i2cBusPkg;

	////////////////////////////////////////
	// Bus side of the controller.
	////////////////////////////////////////

	// One byte on the SDA line, bit 7 first.
	typedef logic [7:0] i2cByte;

	// Phase index, 0 to 21 during a transfer.
	typedef logic [4:0] phaseCount;

	// Sequencer states, one per phase group.
	// Phases 0-1 are startCond, 2-17 dataBit.
	// Phases 18-19 are ackSlot, 20-21 stopCond.
	typedef enum logic [2:0] {
		idle,
		startCond,
		dataBit,
		ackSlot,
		stopCond
	} seqState;

endpackage

`default_nettype wire

// ==== design/i2cApbRegs.sv ====
`timescale 1ns/1ps
`include "i2cMaster_defs.svh"
`default_nettype none

module i2cApbRegs (
	input  wire                    clk,
	input  wire                    reset,
	// APB slave port.
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire i2cRegPkg::apbAddr paddr,
	input  wire i2cRegPkg::apbWord pwdata,
	output i2cRegPkg::apbWord      prdata,
	output logic                   pready,
	output logic                   pslverr,
	// Status from the sequencer.
	input  wire                    busy,
	input  wire i2cBusPkg::i2cByte rxByte,
	input  wire                    rxValid,
	input  wire                    ackBit,
	input  wire                    scl,
	// Settings to the timer and sequencer.
	output i2cRegPkg::baudDiv      divisor,
	output i2cBusPkg::i2cByte      txByte,
	output logic                   doStart,
	output logic                   doStop,
	output logic                   isWrite,
	output logic                   startReq
);

	import i2cRegPkg::*;
	import i2cBusPkg::*;

	////////////////////////////////////////
	// Registers and decode.
	////////////////////////////////////////

	baudDiv  baudReg;
	ctrlBits ctrlReg;
	i2cByte  dataReg;
	apbWord  statusWord;

	logic readyQ;
	logic addrBaud;
	logic addrCtrl;
	logic addrData;
	logic addrHit;
	logic wrCommit;
	logic wrData;

	// Address match against the three word addresses.
	assign addrBaud = (paddr == `I2C_ADDR_BAUD);
	assign addrCtrl = (paddr == `I2C_ADDR_CTRL);
	assign addrData = (paddr == `I2C_ADDR_DATA);
	assign addrHit  = addrBaud | addrCtrl | addrData;

	// Ready rises on the second access cycle.
	// Cleared right after, so it lasts one cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			readyQ <= 1'b0;
		end else begin
			readyQ <= psel & penable & ~readyQ;
		end
	end

	assign pready  = readyQ;
	assign pslverr = readyQ & ~addrHit;

	// Writes take effect in the ready cycle.
	assign wrCommit = psel & penable & readyQ & pwrite;
	// Data writes are dropped while a byte is on the bus.
	assign wrData   = wrCommit & addrData & ~busy;

	////////////////////////////////////////
	// Register writes.
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			baudReg <= '0;
			ctrlReg <= '0;
		end else if (wrCommit) begin
			// Bit 0 of the divisor is not stored.
			if (addrBaud) begin
				baudReg <= {pwdata[15:1], 1'b0};
			end
			// Only the control bits are writable.
			if (addrCtrl) begin
				ctrlReg <= pwdata[3:0];
			end
		end
	end

	// Data register, loaded from the bus or from the shifted byte.
	always_ff @(posedge clk) begin
		if (reset) begin
			dataReg <= '0;
		end else if (wrData) begin
			dataReg <= pwdata[7:0];
		end else if (rxValid) begin
			dataReg <= rxByte;
		end
	end

	// Start pulse one cycle after the data write.
	// By then the data register holds the new byte.
	always_ff @(posedge clk) begin
		if (reset) begin
			startReq <= 1'b0;
		end else begin
			startReq <= wrData & ctrlReg[0];
		end
	end

	////////////////////////////////////////
	// Readback and outputs.
	////////////////////////////////////////

	// Bit 6 SCL, bit 5 done, bit 4 ack result.
	assign statusWord = {9'b0, scl, ~busy, ackBit, ctrlReg};

	always_comb begin
		if (addrBaud) begin
			prdata = baudReg;
		end else if (addrCtrl) begin
			prdata = statusWord;
		end else if (addrData) begin
			prdata = {8'h00, dataReg};
		end else begin
			prdata = '0;
		end
	end

	assign divisor = baudReg;
	assign txByte  = dataReg;
	assign doStart = ctrlReg[3];
	assign doStop  = ctrlReg[2];
	assign isWrite = ctrlReg[1];

endmodule

`default_nettype wire

// ==== design/i2cBaudTimer.sv ====
`timescale 1ns/1ps
`include "i2cMaster_defs.svh"
`default_nettype none

module i2cBaudTimer (
	input  wire                    clk,
	input  wire                    reset,
	input  wire i2cRegPkg::baudDiv divisor,
	input  wire                    busy,
	input  wire                    startReq,
	output logic                   tick
);

	import i2cRegPkg::*;

	////////////////////////////////////////
	// Tick counter.
	////////////////////////////////////////

	baudDiv count;
	baudDiv period;
	logic   match;

	// Divisors below the minimum run at the minimum.
	assign period = (divisor < `I2C_MIN_DIV) ? `I2C_MIN_DIV : divisor;

	// Last cycle of a tick period.
	assign match = (count == period - 16'd1);

	// Restart on a new transfer.
	// Held at zero while the sequencer is idle.
	always_ff @(posedge clk) begin
		if (reset || startReq || !busy || match) begin
			count <= '0;
		end else begin
			count <= count + 16'd1;
		end
	end

	// One pulse per period, only during a transfer.
	assign tick = busy & match;

endmodule

`default_nettype wire

// ==== design/i2cPhaseSequencer.sv ====
`timescale 1ns/1ps
`include "i2cMaster_defs.svh"
`default_nettype none

module i2cPhaseSequencer (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    tick,
	input  wire                    startReq,
	input  wire i2cBusPkg::i2cByte txByte,
	input  wire                    doStart,
	input  wire                    doStop,
	input  wire                    isWrite,
	input  wire                    sdaIn,
	output logic                   busy,
	output i2cBusPkg::i2cByte      rxByte,
	output logic                   rxValid,
	output logic                   ackBit,
	output logic                   scl,
	output logic                   sdaLow
);

	import i2cBusPkg::*;

	seqState   state;
	phaseCount phase;
	phaseCount nextPhase;
	i2cByte    shiftReg;

	// Transfer options, fixed for the length of a transfer.
	logic startFlag;
	logic stopFlag;
	logic writeFlag;

	logic lastPhase;
	logic shiftEn;
	logic ackEn;
	logic sdaLowNext;

	// Phase group of a phase index.
	function automatic seqState groupOf(input phaseCount p);
		if (p < 5'd2) begin
			return startCond;
		end else if (p < 5'd18) begin
			return dataBit;
		end else if (p < 5'd20) begin
			return ackSlot;
		end
		return stopCond;
	endfunction

	////////////////////////////////////////
	// Phase state machine.
	////////////////////////////////////////

	assign nextPhase = phase + 5'd1;
	assign lastPhase = (phase == `I2C_PHASE_LAST);
	assign busy      = (state != idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			phase <= '0;
		end else if (state == idle) begin
			if (startReq) begin
				state <= startCond;
				phase <= '0;
			end
		end else if (tick) begin
			// Tick ends the current phase.
			if (lastPhase) begin
				state <= idle;
				phase <= '0;
			end else begin
				state <= groupOf(nextPhase);
				phase <= nextPhase;
			end
		end
	end

	////////////////////////////////////////
	// Shift register and acknowledge.
	////////////////////////////////////////

	// SCL is high in odd phases, so sample at their end.
	assign shiftEn = tick & (state == dataBit) & phase[0];
	assign ackEn   = tick & (state == ackSlot) & phase[0];

	// The line is shifted in for both directions.
	// In write mode it carries the master's own bits.
	always_ff @(posedge clk) begin
		if (state == idle && startReq) begin
			shiftReg  <= txByte;
			startFlag <= doStart;
			stopFlag  <= doStop;
			writeFlag <= isWrite;
		end else if (shiftEn) begin
			shiftReg <= {shiftReg[6:0], sdaIn};
		end
	end

	// Low means the target acked.
	always_ff @(posedge clk) begin
		if (reset) begin
			ackBit <= 1'b0;
		end else if (ackEn) begin
			ackBit <= sdaIn;
		end
	end

	assign rxByte  = shiftReg;
	// Same cycle as the tick that ends phase 21.
	assign rxValid = tick & lastPhase;

	////////////////////////////////////////
	// SCL and SDA decode.
	////////////////////////////////////////

	always_comb begin
		scl        = 1'b1;
		sdaLowNext = 1'b0;
		case (state)
			startCond: begin
				// START pulls SDA low in phase 1 with SCL high.
				scl        = startFlag ? 1'b1 : phase[0];
				sdaLowNext = startFlag & phase[0];
			end
			dataBit: begin
				scl        = phase[0];
				// MSB first, released in read mode.
				sdaLowNext = writeFlag & ~shiftReg[7];
			end
			ackSlot: begin
				scl        = phase[0];
				// Master acks a read, target acks a write.
				sdaLowNext = ~writeFlag;
			end
			stopCond: begin
				// STOP releases SDA in phase 21 with SCL high.
				scl        = stopFlag ? 1'b1 : phase[0];
				sdaLowNext = stopFlag & ~phase[0];
			end
			default: begin
				// Idle bus.
				scl        = 1'b1;
				sdaLowNext = 1'b0;
			end
		endcase
	end

	// SDA follows one cycle behind SCL.
	// Data changes land while SCL is already low.
	always_ff @(posedge clk) begin
		if (reset) begin
			sdaLow <= 1'b0;
		end else begin
			sdaLow <= sdaLowNext;
		end
	end

endmodule

`default_nettype wire

// ==== design/i2cMasterTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2cMasterTop (
	input  wire                    clk,
	input  wire                    reset,
	// APB slave port.
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire i2cRegPkg::apbAddr paddr,
	input  wire i2cRegPkg::apbWord pwdata,
	output wire i2cRegPkg::apbWord prdata,
	output wire                    pready,
	output wire                    pslverr,
	// I2C pins.
	output wire                    scl,
	output wire                    sdaLow,
	input  wire                    sdaIn
);

	import i2cRegPkg::*;
	import i2cBusPkg::*;

	////////////////////////////////////////
	// Internal nets.
	////////////////////////////////////////

	// Register block to timer and sequencer.
	wire baudDiv divisor;
	wire i2cByte txByte;
	wire         doStart;
	wire         doStop;
	wire         isWrite;
	wire         startReq;

	// Sequencer back to the register block.
	wire         busy;
	wire i2cByte rxByte;
	wire         rxValid;
	wire         ackBit;

	// Timer to sequencer.
	wire         tick;

	////////////////////////////////////////
	// Blocks.
	////////////////////////////////////////

	// Register block.
	i2cApbRegs i2cApbRegs_inst (
		.clk      (clk),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.busy     (busy),
		.rxByte   (rxByte),
		.rxValid  (rxValid),
		.ackBit   (ackBit),
		.scl      (scl),
		.divisor  (divisor),
		.txByte   (txByte),
		.doStart  (doStart),
		.doStop   (doStop),
		.isWrite  (isWrite),
		.startReq (startReq)
	);

	// Phase tick generator.
	i2cBaudTimer i2cBaudTimer_inst (
		.clk      (clk),
		.reset    (reset),
		.divisor  (divisor),
		.busy     (busy),
		.startReq (startReq),
		.tick     (tick)
	);

	// Bus phase sequencer.
	i2cPhaseSequencer i2cPhaseSequencer_inst (
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.startReq (startReq),
		.txByte   (txByte),
		.doStart  (doStart),
		.doStop   (doStop),
		.isWrite  (isWrite),
		.sdaIn    (sdaIn),
		.busy     (busy),
		.rxByte   (rxByte),
		.rxValid  (rxValid),
		.ackBit   (ackBit),
		.scl      (scl),
		.sdaLow   (sdaLow)
	);

endmodule

`default_nettype wire

// ==== tests/i2cTargetModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2cTargetModel (
	input  wire                    scl,
	input  wire                    sda,
	input  wire                    masterLow,
	input  wire                    nackMode,
	input  wire                    readMode,
	input  wire i2cBusPkg::i2cByte txData,
	output logic                   sdaRelease,
	output i2cBusPkg::i2cByte      rxData,
	output logic [7:0]             startCount,
	output logic [7:0]             stopCount,
	output logic [7:0]             byteCount
);

	import i2cBusPkg::*;

	i2cByte shiftIn;
	int     bitCount;
	logic   active;

	initial begin
		sdaRelease = 1'b1;
		rxData     = '0;
		shiftIn    = '0;
		startCount = '0;
		stopCount  = '0;
		byteCount  = '0;
		bitCount   = 0;
		active     = 1'b0;
	end

	////////////////////////////////////////
	// Bus conditions.
	////////////////////////////////////////

	// START, SDA falls with SCL high.
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			startCount++;
			active   = 1'b1;
			bitCount = 0;
		end
	end

	// STOP, SDA rises with SCL high.
	always @(posedge sda) begin
		if (scl === 1'b1) begin
			stopCount++;
			active     = 1'b0;
			sdaRelease = 1'b1;
		end
	end

	////////////////////////////////////////
	// Bit and acknowledge clocks.
	////////////////////////////////////////

	// Sample on the rising edge, bit 7 first.
	always @(posedge scl) begin
		if (active && bitCount < 8) begin
			shiftIn = {shiftIn[6:0], sda};
			bitCount++;
			if (bitCount == 8) begin
				rxData = shiftIn;
				byteCount++;
			end
		end else if (active && bitCount == 8) begin
			// Acknowledge clock.
			bitCount = 9;
		end
	end

	// Drive only while SCL is low.
	always @(negedge scl) begin
		if (active) begin
			if (bitCount < 8) begin
				sdaRelease = readMode ? txData[7 - bitCount] : 1'b1;
			end else if (bitCount == 8) begin
				// Ack a write, leave the slot to the master on a read.
				sdaRelease = readMode ? 1'b1 : nackMode;
			end else begin
				sdaRelease = 1'b1;
			end
		end
	end

	// SCL stays high into STOP, so let go once the master holds SDA.
	always @(posedge masterLow) begin
		if (bitCount == 9) begin
			sdaRelease = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tests/i2cMasterAsserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2cMasterAsserts (
	input wire                       clk,
	input wire                       reset,
	input wire                       psel,
	input wire                       penable,
	input wire                       pready,
	input wire                       startReq,
	input wire                       busy,
	input wire                       scl,
	input wire                       sdaLow,
	input wire i2cBusPkg::phaseCount phase
);

	import i2cBusPkg::*;

	////////////////////////////////////////
	// APB side.
	////////////////////////////////////////

	// One wait state, then ready for one cycle.
	readyPulse: assert property (@(posedge clk) disable iff (reset)
		$rose(psel && penable) |-> !pready ##1 pready ##1 !pready)
		else $error("pready did not follow one wait state for exactly one cycle");

	// No new transfer on top of a running one.
	startWhileIdle: assert property (@(posedge clk) disable iff (reset)
		startReq |-> !busy)
		else $error("startReq raised while the sequencer was busy");

	////////////////////////////////////////
	// Pin side.
	////////////////////////////////////////

	// Data and ack phases 2 to 19.
	// START and STOP are the only SDA edges under a high SCL.
	sdaStable: assert property (@(posedge clk) disable iff (reset)
		(busy && phase >= 5'd2 && phase <= 5'd19 && $changed(sdaLow)) |-> !scl)
		else $error("SDA drive changed while SCL was high in a data phase");

endmodule

bind i2cMasterTop i2cMasterAsserts i2cMasterAsserts_inst (
	.clk      (clk),
	.reset    (reset),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.startReq (startReq),
	.busy     (busy),
	.scl      (scl),
	.sdaLow   (sdaLow),
	.phase    (i2cPhaseSequencer_inst.phase)
);

`default_nettype wire

// ==== tests/i2cMasterTb.sv ====
`timescale 1ns/1ps
`include "i2cMaster_defs.svh"
`default_nettype none

module i2cMasterTb;

	import i2cRegPkg::*;
	import i2cBusPkg::*;

	////////////////////////////////////////
	// DUT, target and the SDA wire.
	////////////////////////////////////////

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apbAddr      paddr;
	apbWord      pwdata;
	wire apbWord prdata;
	wire         pready;
	wire         pslverr;
	wire         scl;
	wire         sdaLow;
	wire         sdaLine;
	wire         targetRelease;

	logic        targetNack;
	logic        targetRead;
	i2cByte      targetTx;
	wire i2cByte targetRx;
	wire [7:0]   startCount;
	wire [7:0]   stopCount;
	wire [7:0]   byteCount;

	// Reference model of the register map.
	baudDiv  baudModel;
	ctrlBits ctrlModel;
	i2cByte  dataModel;
	logic    ackModel;

	int     seed = 45400;
	int     errorCount = 0;
	int     testCount = 0;
	int     passCount = 0;
	int     startBase;
	int     stopBase;
	int     byteBase;
	int     activeCycles;
	int     lowRuns[$];
	int     highRuns[$];
	int     runLen;
	logic   sclLast;
	apbWord lastStatus;

	// Open drain, low if either side pulls.
	assign sdaLine = ~sdaLow & targetRelease;

	i2cMasterTop i2cMasterTop_inst (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.scl     (scl),
		.sdaLow  (sdaLow),
		.sdaIn   (sdaLine)
	);

	i2cTargetModel i2cTargetModel_inst (
		.scl        (scl),
		.sda        (sdaLine),
		.masterLow  (sdaLow),
		.nackMode   (targetNack),
		.readMode   (targetRead),
		.txData     (targetTx),
		.sdaRelease (targetRelease),
		.rxData     (targetRx),
		.startCount (startCount),
		.stopCount  (stopCount),
		.byteCount  (byteCount)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////
	// Monitors.
	////////////////////////////////////////

	// Cycles from the start request to the end of busy.
	always @(posedge clk) begin
		if (i2cMasterTop_inst.startReq || i2cMasterTop_inst.busy) begin
			activeCycles++;
		end
	end

	// SCL high and low run lengths in clk cycles.
	always @(posedge clk) begin
		if (reset) begin
			sclLast = 1'b1;
			runLen  = 0;
		end else if (scl == sclLast) begin
			runLen++;
		end else begin
			if (sclLast) begin
				highRuns.push_back(runLen);
			end else begin
				lowRuns.push_back(runLen);
			end
			sclLast = scl;
			runLen  = 1;
		end
	end

	////////////////////////////////////////
	// Checks and model helpers.
	////////////////////////////////////////

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got, expected);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %0d %s: pass", testCount, name);
		end else begin
			$display("test %0d %s: fail with %0d errors", testCount, name,
				errorCount - errorsBefore);
		end
	endtask

	// Bit 6 SCL idle high, bit 5 done.
	function automatic apbWord statusModel();
		return {9'b0, 1'b1, 1'b1, ackModel, ctrlModel};
	endfunction

	// Divisors under the minimum run at the minimum.
	function automatic int periodModel();
		if (baudModel < `I2C_MIN_DIV) begin
			return `I2C_MIN_DIV;
		end
		return baudModel;
	endfunction

	////////////////////////////////////////
	// APB tasks.
	////////////////////////////////////////

	task automatic apbAccess(input logic write, input apbAddr addr, input apbWord wdata,
			output apbWord rdata, output logic err);
		int waitCycles;
		waitCycles = 0;
		rdata      = '0;
		err        = 1'b0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		// Sampled mid-cycle, where the outputs are stable.
		do begin
			@(negedge clk);
			waitCycles++;
		end while (!pready && waitCycles < 8);
		if (pready) begin
			rdata = prdata;
			err   = pslverr;
			// Exactly one wait state.
			checkValue("APB access cycles", waitCycles, 2);
		end else begin
			$display("APB timeout at %0t ns: pready never rose", $time);
			errorCount++;
		end
		// The access commits on this edge.
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input apbAddr addr, input apbWord wdata);
		apbWord unused;
		logic   err;
		apbAccess(1'b1, addr, wdata, unused, err);
		checkValue("APB write pslverr", err, 1'b0);
	endtask

	task automatic apbRead(input apbAddr addr, output apbWord rdata);
		logic err;
		apbAccess(1'b0, addr, '0, rdata, err);
		checkValue("APB read pslverr", err, 1'b0);
	endtask

	task automatic setDivisor(input apbWord value);
		apbWrite(`I2C_ADDR_BAUD, value);
		baudModel = {value[15:1], 1'b0};
	endtask

	// One byte with START and STOP, polled until done.
	task automatic runTransfer(input i2cByte txData, input logic write,
			input logic secondWrite, input i2cByte secondData);
		apbWord status;
		int     polls;
		ctrlModel = {1'b1, 1'b1, write, 1'b1};
		apbWrite(`I2C_ADDR_CTRL, {12'h000, ctrlModel});
		startBase    = startCount;
		stopBase     = stopCount;
		byteBase     = byteCount;
		activeCycles = 0;
		lowRuns.delete();
		highRuns.delete();
		apbWrite(`I2C_ADDR_DATA, {8'h00, txData});
		// Lands while the first byte is on the bus.
		if (secondWrite) begin
			apbWrite(`I2C_ADDR_DATA, {8'h00, secondData});
		end
		status = '0;
		polls  = 0;
		while (!status[5] && polls < 500) begin
			apbRead(`I2C_ADDR_CTRL, status);
			polls++;
		end
		if (!status[5]) begin
			$display("Transfer timeout: done never set after %0d status polls", polls);
			errorCount++;
		end
		lastStatus = status;
	endtask

	////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////

	initial begin
		int     i;
		int     errorsBefore;
		apbWord value;
		apbWord readBack;
		apbAddr badAddr;
		logic   err;
		i2cByte txData;
		clk        = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		targetNack = 1'b0;
		targetRead = 1'b0;
		targetTx   = '0;
		baudModel  = '0;
		ctrlModel  = '0;
		dataModel  = '0;
		ackModel   = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Register round trip.
		errorsBefore = errorCount;
		for (i = 0; i < 4; i++) begin
			value = $random(seed);
			setDivisor(value);
			apbRead(`I2C_ADDR_BAUD, readBack);
			checkValue("baud readback", readBack, baudModel);
			value = $random(seed);
			apbWrite(`I2C_ADDR_CTRL, value);
			ctrlModel = value[3:0];
			apbRead(`I2C_ADDR_CTRL, readBack);
			checkValue("control readback", readBack, statusModel());
		end
		// Enable off, so the data write starts nothing.
		ctrlModel = '0;
		apbWrite(`I2C_ADDR_CTRL, '0);
		value = $random(seed);
		apbWrite(`I2C_ADDR_DATA, value);
		dataModel = value[7:0];
		apbRead(`I2C_ADDR_DATA, readBack);
		checkValue("data readback", readBack, {8'h00, dataModel});
		badAddr = $random(seed);
		if (badAddr == `I2C_ADDR_BAUD || badAddr == `I2C_ADDR_CTRL ||
				badAddr == `I2C_ADDR_DATA) begin
			badAddr = 4'hC;
		end
		apbAccess(1'b0, badAddr, '0, readBack, err);
		checkValue("unmapped address pslverr", err, 1'b1);
		reportTest("register round trip", errorsBefore);

		// Write transfer, target acks.
		errorsBefore = errorCount;
		value = 4 + ($unsigned($random(seed)) % 17);
		setDivisor(value);
		txData = $random(seed);
		runTransfer(txData, 1'b1, 1'b0, 8'h00);
		dataModel = txData;
		ackModel  = 1'b0;
		checkValue("START count", startCount - startBase, 1);
		checkValue("STOP count", stopCount - stopBase, 1);
		checkValue("bytes seen by target", byteCount - byteBase, 1);
		checkValue("target byte", targetRx, txData);
		checkValue("status after write", lastStatus, statusModel());
		apbRead(`I2C_ADDR_DATA, readBack);
		checkValue("data after write", readBack, {8'h00, dataModel});
		reportTest("write transfer", errorsBefore);

		// Target refuses the byte.
		errorsBefore = errorCount;
		targetNack = 1'b1;
		txData = $random(seed);
		runTransfer(txData, 1'b1, 1'b0, 8'h00);
		targetNack = 1'b0;
		dataModel  = txData;
		ackModel   = 1'b1;
		checkValue("STOP count after nack", stopCount - stopBase, 1);
		checkValue("status after nack", lastStatus, statusModel());
		reportTest("nack", errorsBefore);

		// Read transfer, target supplies the byte.
		errorsBefore = errorCount;
		targetRead = 1'b1;
		targetTx   = $random(seed);
		txData     = $random(seed);
		runTransfer(txData, 1'b0, 1'b0, 8'h00);
		targetRead = 1'b0;
		dataModel  = targetTx;
		ackModel   = 1'b0;
		checkValue("START count on read", startCount - startBase, 1);
		checkValue("STOP count on read", stopCount - stopBase, 1);
		checkValue("status after read", lastStatus, statusModel());
		apbRead(`I2C_ADDR_DATA, readBack);
		checkValue("data after read", readBack, {8'h00, dataModel});
		reportTest("read transfer", errorsBefore);

		// SCL timing and busy length.
		errorsBefore = errorCount;
		value = 4 + ($unsigned($random(seed)) % 17);
		setDivisor(value);
		txData = $random(seed);
		runTransfer(txData, 1'b1, 1'b0, 8'h00);
		dataModel = txData;
		// Phases 2 to 18 give 9 lows and 8 highs, after the idle high.
		checkValue("SCL low runs", lowRuns.size(), 9);
		checkValue("SCL high runs", highRuns.size(), 9);
		for (i = 0; i < lowRuns.size(); i++) begin
			checkValue("SCL low time", lowRuns[i], periodModel());
		end
		for (i = 1; i < highRuns.size(); i++) begin
			checkValue("SCL high time", highRuns[i], periodModel());
		end
		checkValue("busy cycles", activeCycles, 22 * periodModel() + 1);
		reportTest("timing", errorsBefore);

		// Data write during busy is dropped.
		errorsBefore = errorCount;
		txData = $random(seed);
		runTransfer(txData, 1'b1, 1'b1, ~txData);
		dataModel = txData;
		checkValue("START count with second write", startCount - startBase, 1);
		checkValue("bytes with second write", byteCount - byteBase, 1);
		checkValue("target byte with second write", targetRx, txData);
		checkValue("single transfer length", activeCycles, 22 * periodModel() + 1);
		apbRead(`I2C_ADDR_DATA, readBack);
		checkValue("data with second write", readBack, {8'h00, dataModel});
		reportTest("busy protection", errorsBefore);

		$display("%0d of %0d tests passed, %0d errors", passCount, testCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/i2cRegPkg.sv
design/i2cBusPkg.sv
design/i2cApbRegs.sv
design/i2cBaudTimer.sv
design/i2cPhaseSequencer.sv
design/i2cMasterTop.sv
tests/i2cTargetModel.sv
tests/i2cMasterAsserts.sv
tests/i2cMasterTb.sv
